//--- retire_unit.f
+incdir+rtl
rtl/retire_pkg.sv
rtl/retire_if.sv
rtl/reorder_buffer.sv
rtl/stage_rt.sv
rtl/arch_regfile.sv
rtl/retire_unit.sv
tb/tb_clock_gen.sv
tb/retire_unit_tb.sv

//--- rtl/arch_regfile.sv
// architectural register file, one write from retirement, one combinational read, x0 is zero
`timescale 1ns/1ps
`default_nettype none

`include "retire_defines.svh"

module arch_regfile import retire_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    // write from retire
    input  logic      write_enable,
    input  reg_addr_t write_addr,
    input  word_t     write_data,
    // read port
    input  reg_addr_t read_addr,
    output word_t     read_data
);

    localparam int NUM_REGS = 1 << `RT_REG_ADDR_W;  // 32

    word_t regs [NUM_REGS];

    ////////////////////
    // write
    ////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // architectural state starts at zero
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_addr != '0)) begin
            regs[write_addr] <= write_data;  // x0 writes dropped
        end
    end

    ////////////////////
    // read
    ////////////////////

    // no bypass, a write shows up the cycle after retire_valid
    assign read_data = (read_addr == '0) ? '0 : regs[read_addr];

endmodule

`default_nettype wire

//--- rtl/reorder_buffer.sv
// circular reorder buffer: tags on dispatch, out of order completion, in order release at head
`timescale 1ns/1ps
`default_nettype none

`include "retire_defines.svh"

module reorder_buffer import retire_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    // dispatch, program order
    input  logic      dispatch_valid,
    input  reg_addr_t dispatch_dest,
    input  logic      dispatch_is_store,
    input  logic      dispatch_is_branch,
    output logic      dispatch_ready,
    output rob_tag_t  dispatch_tag,        // slot the accepted instruction lands in
    // completion, any order, no back-pressure
    input  logic      complete_valid,
    input  rob_tag_t  complete_tag,
    input  word_t     complete_value,
    input  word_t     complete_mem_addr,
    input  logic      complete_mispredict,
    // oldest entry toward retire
    retire_if.rob     head
);

    localparam rob_count_t ROB_FULL = rob_count_t'(`RT_ROB_DEPTH);

    ////////////////////
    // state
    ////////////////////

    rob_tag_t   head_ptr;  // oldest entry
    rob_tag_t   tail_ptr;  // next free slot
    rob_count_t count;     // entries in flight
    logic       alive;     // low during reset, blocks dispatch until the first cycle out

    // per slot flags
    logic [`RT_ROB_DEPTH-1:0] slot_busy;
    logic [`RT_ROB_DEPTH-1:0] slot_done;
    logic [`RT_ROB_DEPTH-1:0] slot_is_store;
    logic [`RT_ROB_DEPTH-1:0] slot_is_branch;
    logic [`RT_ROB_DEPTH-1:0] slot_mispredict;

    // per slot payload
    reg_addr_t slot_dest  [`RT_ROB_DEPTH];
    word_t     slot_value [`RT_ROB_DEPTH];
    word_t     slot_addr  [`RT_ROB_DEPTH];

    rob_tag_t head_next;
    logic     dispatch_fire;
    logic     release_head;
    logic     flush;

    ////////////////////
    // head view
    ////////////////////

    assign head.rob_valid = slot_busy[head_ptr];
    assign head.rob_ready = slot_done[head_ptr];     // done is cleared whenever a slot frees
    assign head.value     = slot_value[head_ptr];
    assign head.dest_reg  = slot_dest[head_ptr];
    assign head.mem_addr  = slot_addr[head_ptr];
    assign head.is_store  = slot_is_store[head_ptr];
    assign head.branch_mispredict = slot_busy[head_ptr] & slot_done[head_ptr]
                                  & slot_is_branch[head_ptr] & slot_mispredict[head_ptr];

    assign release_head = head.rob_valid & head.rob_ready;    // one per cycle
    assign flush        = release_head & head.branch_mispredict; // squash all younger
    assign head_next    = head_ptr + rob_tag_t'(1);

    // no dispatch while full or while the younger entries are being thrown away
    assign dispatch_ready = alive & (count != ROB_FULL) & ~flush;
    assign dispatch_tag   = tail_ptr;
    assign dispatch_fire  = dispatch_valid & dispatch_ready;

    ////////////////////
    // pointers and count
    ////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            alive    <= 1'b0;
        end else begin
            alive <= 1'b1;
            if (release_head)
                head_ptr <= head_next;
            if (flush) begin
                tail_ptr <= head_next;  // tail snaps back onto the new head
                count    <= '0;         // branch left, everything behind it gone
            end else begin
                if (dispatch_fire)
                    tail_ptr <= tail_ptr + rob_tag_t'(1);
                count <= count + rob_count_t'(dispatch_fire) - rob_count_t'(release_head);
            end
        end
    end

    // busy and done, order matters: flush clear wins over a same cycle completion
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            slot_busy <= '0;
            slot_done <= '0;
        end else begin
            if (dispatch_fire) begin
                slot_busy[tail_ptr] <= 1'b1;
                slot_done[tail_ptr] <= 1'b0;
            end
            if (complete_valid)
                slot_done[complete_tag] <= 1'b1;
            if (release_head) begin
                slot_busy[head_ptr] <= 1'b0;
                slot_done[head_ptr] <= 1'b0;
            end
            if (flush) begin
                slot_busy <= '0;
                slot_done <= '0;
            end
        end
    end

    // payload, written at dispatch and at completion
    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            slot_dest[tail_ptr]       <= dispatch_dest;
            slot_is_store[tail_ptr]   <= dispatch_is_store;
            slot_is_branch[tail_ptr]  <= dispatch_is_branch;
            slot_mispredict[tail_ptr] <= 1'b0;
        end
        if (complete_valid) begin
            slot_value[complete_tag]      <= complete_value;
            slot_addr[complete_tag]       <= complete_mem_addr;
            slot_mispredict[complete_tag] <= complete_mispredict; // only branches set this
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // execution side may only finish something that is in flight and not finished yet
    a_complete_live: assert property (@(posedge clock) disable iff (!rst_n)
        complete_valid |-> slot_busy[complete_tag] && !slot_done[complete_tag])
        else $error("completion for tag %0d that is free or already done", complete_tag);

    a_count_bound: assert property (@(posedge clock) disable iff (!rst_n)
        count <= ROB_FULL)
        else $error("occupancy %0d past depth", count);

endmodule

`default_nettype wire

//--- rtl/retire_defines.svh
// shared width and depth macros for the retire subsystem, include wherever a size is needed
`ifndef RETIRE_DEFINES_SVH
`define RETIRE_DEFINES_SVH

////////////////////
// datapath widths
////////////////////

// result values, store data and store addresses
`define RT_XLEN 64

// architectural register number, 32 registers
`define RT_REG_ADDR_W 5

////////////////////
// reorder buffer
////////////////////

// entries in flight, keep a power of two so pointers wrap for free
`define RT_ROB_DEPTH 8

// log2 of RT_ROB_DEPTH, change both together
`define RT_ROB_TAG_W 3

`endif

//--- rtl/retire_if.sv
// head entry of the reorder buffer as offered to the retire stage, one entry per cycle
`timescale 1ns/1ps
`default_nettype none

interface retire_if import retire_pkg::*; ();

    logic      rob_valid;         // head slot occupied
    logic      rob_ready;         // head entry completed
    word_t     value;             // result, or store data
    reg_addr_t dest_reg;          // destination register
    word_t     mem_addr;          // store address
    logic      is_store;          // head is a store
    logic      branch_mispredict; // head is a completed, mispredicted branch

    // buffer side drives everything
    modport rob (
        output rob_valid, rob_ready, value, dest_reg, mem_addr, is_store,
               branch_mispredict
    );

    // retire side only listens, never stalls
    modport rt (
        input rob_valid, rob_ready, value, dest_reg, mem_addr, is_store,
              branch_mispredict
    );

endinterface

`default_nettype wire

//--- rtl/retire_pkg.sv
// vector types shared by the retire RTL and its testbench, pull in with a wildcard import
`default_nettype none

`include "retire_defines.svh"

package retire_pkg;

    ////////////////////
    // datapath
    ////////////////////

    // result value, store data or store address
    typedef logic [`RT_XLEN-1:0] word_t;

    // architectural register number
    typedef logic [`RT_REG_ADDR_W-1:0] reg_addr_t;

    ////////////////////
    // reorder buffer
    ////////////////////

    // slot index, doubles as the tag handed out at dispatch
    typedef logic [`RT_ROB_TAG_W-1:0] rob_tag_t;

    // occupancy 0..depth, one bit wider than a tag
    typedef logic [`RT_ROB_TAG_W:0] rob_count_t;

endpackage

`default_nettype wire

//--- rtl/retire_unit.sv
// top of the retire subsystem, reorder buffer into retire stage into register file
`timescale 1ns/1ps
`default_nettype none

module retire_unit import retire_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    // dispatch
    input  logic      dispatch_valid,
    input  reg_addr_t dispatch_dest,
    input  logic      dispatch_is_store,
    input  logic      dispatch_is_branch,
    output logic      dispatch_ready,
    output rob_tag_t  dispatch_tag,
    // completion
    input  logic      complete_valid,
    input  rob_tag_t  complete_tag,
    input  word_t     complete_value,
    input  word_t     complete_mem_addr,
    input  logic      complete_mispredict,
    // retire and recovery
    output logic      retire_valid,
    output reg_addr_t retire_dest,
    output word_t     retire_value,
    output logic      store_valid,
    output word_t     store_addr,
    output word_t     store_data,
    output logic      recovery_valid,
    // register read
    input  reg_addr_t read_addr,
    output word_t     read_data
);

    retire_if head_if ();  // buffer head toward retire

    reorder_buffer rob0 (
        .clock               (clock),
        .rst_n               (rst_n),
        .dispatch_valid      (dispatch_valid),
        .dispatch_dest       (dispatch_dest),
        .dispatch_is_store   (dispatch_is_store),
        .dispatch_is_branch  (dispatch_is_branch),
        .dispatch_ready      (dispatch_ready),
        .dispatch_tag        (dispatch_tag),
        .complete_valid      (complete_valid),
        .complete_tag        (complete_tag),
        .complete_value      (complete_value),
        .complete_mem_addr   (complete_mem_addr),
        .complete_mispredict (complete_mispredict),
        .head                (head_if.rob)
    );

    stage_rt rt0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .head           (head_if.rt),
        .retire_valid   (retire_valid),
        .retire_dest    (retire_dest),
        .retire_value   (retire_value),
        .store_valid    (store_valid),
        .store_addr     (store_addr),
        .store_data     (store_data),
        .recovery_valid (recovery_valid)
    );

    // retire outputs double as the write port
    arch_regfile rf0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .write_enable (retire_valid),
        .write_addr   (retire_dest),
        .write_data   (retire_value),
        .read_addr    (read_addr),
        .read_data    (read_data)
    );

endmodule

`default_nettype wire

//--- rtl/stage_rt.sv
// retire stage that registers the released head into register write, store commit and recovery
`timescale 1ns/1ps
`default_nettype none

module stage_rt import retire_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    retire_if.rt      head,            // released when valid and ready
    // register file write
    output logic      retire_valid,
    output reg_addr_t retire_dest,
    output word_t     retire_value,
    // store commit
    output logic      store_valid,
    output word_t     store_addr,
    output word_t     store_data,
    // branch recovery
    output logic      recovery_valid
);

    logic take;  // head leaves the buffer this edge

    assign take = head.rob_valid & head.rob_ready;

    // one cycle valid pulses that drop on every idle cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            retire_valid   <= 1'b0;
            store_valid    <= 1'b0;
            recovery_valid <= 1'b0;
        end else begin
            // plain result only when the destination is not x0
            retire_valid   <= take & ~head.branch_mispredict & ~head.is_store
                            & (head.dest_reg != '0);
            store_valid    <= take & ~head.branch_mispredict & head.is_store;
            recovery_valid <= take & head.branch_mispredict; // no write on a mispredict
        end
    end

    // payload only meaningful alongside its valid
    always_ff @(posedge clock) begin
        if (take) begin
            retire_dest  <= head.dest_reg;
            retire_value <= head.value;
            store_addr   <= head.mem_addr;
            store_data   <= head.value;    // stores carry data in the value field
        end
    end

    ////////////////////
    // checks
    ////////////////////

    a_one_kind: assert property (@(posedge clock) disable iff (!rst_n)
        !(retire_valid && store_valid))
        else $error("register write and store commit in the same cycle");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the retire_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f retire_unit.f \
    --top-module retire_unit_tb \
    -o sim_retire_unit

output=$(./obj_dir/sim_retire_unit)
echo "$output"

if grep -qx "NO ERRORS" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- tb/retire_unit_tb.sv
// retire_unit testbench with directed cases and a random mix against an in-order model
`timescale 1ns/1ps
`default_nettype none

module retire_unit_tb import retire_pkg::*; ();

    localparam int K_NONE = 0, K_RET = 1, K_STORE = 2, K_REC = 3;
    localparam int MAX_IDS = 2048;
    localparam int CYCLE_LIMIT = 4000;  // about four times the whole run

    logic clock, rst_n;
    logic dispatch_valid, dispatch_is_store, dispatch_is_branch, dispatch_ready;
    reg_addr_t dispatch_dest, retire_dest, read_addr;
    rob_tag_t dispatch_tag, complete_tag;
    logic complete_valid, complete_mispredict;
    word_t complete_value, complete_mem_addr, retire_value, store_addr, store_data, read_data;
    logic retire_valid, store_valid, recovery_valid;

    tb_clock_gen clk0 (.clock(clock), .rst_n(rst_n));

    retire_unit dut0 (.*);

    ////////////////////
    // model state
    ////////////////////

    // per instruction fields indexed by program order id
    reg_addr_t e_dest [MAX_IDS];
    bit e_store [MAX_IDS], e_branch [MAX_IDS], e_mis [MAX_IDS], e_done [MAX_IDS];
    rob_tag_t e_tag [MAX_IDS];
    word_t e_value [MAX_IDS], e_addr [MAX_IDS];

    int order_q [$];        // in flight with the oldest first
    word_t shadow [32];     // expected register contents
    reg_addr_t rd_addr_q [$];
    word_t rd_exp_q [$];    // pending read_data checks
    rob_tag_t exp_tag;      // tail the DUT should hand out next
    int next_id = 0;
    int errors = 0;
    int cycle_count = 0;
    bit reader_on = 0;

    task automatic report_mismatch(input string name, input word_t exp, input word_t got);
        errors++;
        $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error at t=%0t: %s", $time, what);
    endtask

    // outcome of the oldest entry by the retire rules
    function automatic int expected_kind(input int id);
        if (e_branch[id] && e_mis[id])
            return K_REC;
        if (e_store[id])
            return K_STORE;
        if (e_dest[id] != '0)
            return K_RET;
        return K_NONE;  // x0 result released silently
    endfunction

    // anything left that should still show up on an output
    function automatic bit outputs_pending();
        foreach (order_q[i])
            if (expected_kind(order_q[i]) != K_NONE)
                return 1;
        return (rd_addr_q.size() > 0);
    endfunction

    ////////////////////
    // driving
    ////////////////////

    // one cycle of dispatch and completion with inputs moved 1 ns after the edge
    task automatic drive_cycle(input bit disp, input reg_addr_t dest, input bit st,
                               input bit br, input bit comp, input int cid,
                               input bit mis, output bit acc);
        @(posedge clock);
        #1;
        dispatch_valid      = disp;
        dispatch_dest       = dest;
        dispatch_is_store   = st;
        dispatch_is_branch  = br;
        complete_valid      = comp;
        complete_tag        = comp ? e_tag[cid] : '0;
        complete_value      = {$urandom, $urandom};
        complete_mem_addr   = {$urandom, $urandom};
        complete_mispredict = comp & mis;
        @(negedge clock);  // handshake sampled where it is stable
        acc = disp && dispatch_ready;
        if (acc) begin
            if (dispatch_tag !== exp_tag)
                report_mismatch("dispatch_tag", word_t'(exp_tag), word_t'(dispatch_tag));
            e_dest[next_id] = dest;
            e_store[next_id] = st;
            e_branch[next_id] = br;
            e_mis[next_id] = 0;
            e_done[next_id] = 0;
            e_tag[next_id] = exp_tag;
            order_q.push_back(next_id);
            next_id++;
            exp_tag++;
        end
        if (comp) begin
            e_done[cid] = 1;
            e_mis[cid] = mis;
            e_value[cid] = complete_value;
            e_addr[cid] = complete_mem_addr;
        end
    endtask

    task automatic idle_cycle();
        bit acc;
        drive_cycle(0, '0, 0, 0, 0, 0, 0, acc);
    endtask

    task automatic dispatch_one(input reg_addr_t dest, input bit st, input bit br,
                                output int id);
        bit acc;
        acc = 0;
        while (!acc)
            drive_cycle(1, dest, st, br, 0, 0, 0, acc);
        id = next_id - 1;
    endtask

    task automatic complete_one(input int id, input bit mis);
        bit acc;
        drive_cycle(0, '0, 0, 0, 1, id, mis, acc);
    endtask

    task automatic wait_drained();
        while (outputs_pending())
            idle_cycle();
    endtask

    ////////////////////
    // checking
    ////////////////////

    // compares every valid output against the oldest model entry
    always @(negedge clock) begin : monitor
        int id;
        int k;
        if (rst_n && (retire_valid || store_valid || recovery_valid)) begin
            while (order_q.size() > 0 && expected_kind(order_q[0]) == K_NONE) begin
                id = order_q.pop_front();
                if (!e_done[id])
                    report_error("x0 entry passed before it completed");
                rd_addr_q.push_back('0);
                rd_exp_q.push_back('0);
            end
            if (order_q.size() == 0) begin
                report_error("retire output with no instruction in flight");
            end else begin
                id = order_q.pop_front();
                k = expected_kind(id);
                if (!e_done[id])
                    report_error("instruction retired before it completed");
                if (retire_valid !== (k == K_RET))
                    report_mismatch("retire_valid", word_t'(k == K_RET), word_t'(retire_valid));
                if (store_valid !== (k == K_STORE))
                    report_mismatch("store_valid", word_t'(k == K_STORE), word_t'(store_valid));
                if (recovery_valid !== (k == K_REC))
                    report_mismatch("recovery_valid", word_t'(k == K_REC),
                                    word_t'(recovery_valid));
                if (k == K_RET) begin
                    if (retire_dest !== e_dest[id])
                        report_mismatch("retire_dest", word_t'(e_dest[id]), word_t'(retire_dest));
                    if (retire_value !== e_value[id])
                        report_mismatch("retire_value", e_value[id], retire_value);
                    shadow[e_dest[id]] = e_value[id];
                end
                if (k == K_STORE) begin
                    if (store_addr !== e_addr[id])
                        report_mismatch("store_addr", e_addr[id], store_addr);
                    if (store_data !== e_value[id])
                        report_mismatch("store_data", e_value[id], store_data);
                end
                if (k == K_REC) begin
                    order_q.delete();            // younger work is gone
                    exp_tag = e_tag[id] + 1'b1;  // tail restarts behind the branch
                end else begin
                    // reads still queued happen after this write lands
                    foreach (rd_addr_q[j])
                        if (rd_addr_q[j] == e_dest[id])
                            rd_exp_q[j] = shadow[e_dest[id]];
                    rd_addr_q.push_back(e_dest[id]);   // store checks the reg stays put
                    rd_exp_q.push_back(shadow[e_dest[id]]);
                end
            end
        end
    end

    // reads back each written register a cycle after the write lands
    always @(posedge clock) begin : reader
        word_t exp;
        if (reader_on && rd_addr_q.size() > 0) begin
            #1;
            read_addr = rd_addr_q.pop_front();
            exp = rd_exp_q.pop_front();
            #1;
            if (read_data !== exp)
                report_mismatch("read_data", exp, read_data);
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin : stimulus
        int ids [8];
        int br_id, n_disp, drain_id, pick;
        bit acc, draining, mis, st, br;
        int cands [$];
        bit [6:0] ret_pattern;
        dispatch_valid = 0;
        dispatch_dest = '0;
        dispatch_is_store = 0;
        dispatch_is_branch = 0;
        complete_valid = 0;
        complete_tag = '0;
        complete_value = '0;
        complete_mem_addr = '0;
        complete_mispredict = 0;
        read_addr = '0;
        exp_tag = '0;
        void'($urandom(2177));
        foreach (shadow[i])
            shadow[i] = '0;

        // after reset the outputs are quiet, dispatch is open and registers are clear
        wait (rst_n);
        idle_cycle();
        idle_cycle();
        if (retire_valid || store_valid || recovery_valid)
            report_error("valid output high after reset");
        if (dispatch_ready !== 1'b1)
            report_mismatch("dispatch_ready", 1, word_t'(dispatch_ready));
        for (int r = 0; r < 32; r++) begin
            @(posedge clock);
            #1 read_addr = reg_addr_t'(r);
            #1;
            if (read_data !== '0)
                report_mismatch("read_data", '0, read_data);
        end
        reader_on = 1;

        // reverse completion still retires in program order including x0
        dispatch_one(5'd1, 0, 0, ids[0]);
        dispatch_one(5'd2, 0, 0, ids[1]);
        dispatch_one(5'd3, 0, 0, ids[2]);
        dispatch_one(5'd0, 0, 0, ids[3]);
        dispatch_one(5'd4, 0, 0, ids[4]);
        dispatch_one(5'd31, 0, 0, ids[5]);
        for (int i = 5; i >= 0; i--)
            complete_one(ids[i], 0);
        // head leaves one edge after its completion and the rest follow one per cycle
        ret_pattern = 7'b1101110;  // bit c is retire_valid c + 1 cycles after the last completion
        for (int c = 0; c < 7; c++) begin
            idle_cycle();
            if (retire_valid !== ret_pattern[c])
                report_mismatch("retire_valid", word_t'(ret_pattern[c]), word_t'(retire_valid));
        end
        wait_drained();

        // store commits without touching its register
        dispatch_one(5'd3, 1, 0, ids[0]);
        complete_one(ids[0], 0);
        wait_drained();

        // fill all eight slots then stay blocked until one retires
        for (int i = 0; i < 8; i++)
            dispatch_one(reg_addr_t'(i + 8), 0, 0, ids[i]);
        repeat (3) begin
            drive_cycle(1, 5'd20, 0, 0, 0, 0, 0, acc);
            if (acc)
                report_error("dispatch accepted while the buffer was full");
        end
        complete_one(ids[0], 0);
        drive_cycle(1, 5'd21, 0, 0, 0, 0, 0, acc);  // head not released yet
        if (acc)
            report_error("dispatch accepted before the head retired");
        dispatch_one(5'd21, 0, 0, br_id);   // tag wraps onto the freed slot
        for (int i = 7; i >= 1; i--)
            complete_one(ids[i], 0);
        complete_one(br_id, 0);
        wait_drained();

        // mispredict drops finished younger work and the tags get reused
        dispatch_one(5'd6, 0, 1, br_id);
        dispatch_one(5'd7, 0, 0, ids[0]);
        dispatch_one(5'd8, 1, 0, ids[1]);
        dispatch_one(5'd9, 0, 0, ids[2]);
        for (int i = 0; i < 3; i++)
            complete_one(ids[i], 0);
        complete_one(br_id, 1);
        while (order_q.size() > 0)
            idle_cycle();
        dispatch_one(5'd10, 0, 0, ids[0]);
        dispatch_one(5'd11, 0, 0, ids[1]);
        complete_one(ids[1], 0);
        complete_one(ids[0], 0);
        wait_drained();

        // random mix
        n_disp = 0;
        draining = 0;
        drain_id = -1;
        cands.delete();
        while (n_disp < 600 || draining || cands.size() > 0) begin
            cands.delete();
            foreach (order_q[i]) begin
                if (draining && order_q[i] == drain_id)
                    break;
                if (!e_done[order_q[i]])
                    cands.push_back(order_q[i]);
            end
            pick = -1;
            if (cands.size() > 0 && ($urandom % 10) < 6)
                pick = cands[$urandom % cands.size()];
            mis = (pick >= 0) && !draining && e_branch[pick] && (($urandom % 4) == 0);
            st = (($urandom % 10) < 2);
            br = !st && (($urandom % 20) < 3);
            drive_cycle(!draining && n_disp < 600 && ($urandom % 10) < 7,
                        reg_addr_t'($urandom % 32), st, br,
                        pick >= 0, pick, mis, acc);
            if (acc)
                n_disp++;
            if (mis) begin
                draining = 1;  // only older entries finish until recovery
                drain_id = pick;
            end
            if (draining && order_q.size() == 0)
                draining = 0;
        end
        wait_drained();
        repeat (4) idle_cycle();

        $display("checks done, %0d errors", errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// testbench clock and reset source, 4 ns clock with rst_n held low for 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clock);
        #1 rst_n = 1'b1;  // released off the edge, like other inputs
    end

endmodule

`default_nettype wire
